/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rvc_expander
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
FILELIST  ?= sim.f

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

/* common/rv32i_pkg.sv */
package rv32i_pkg;

    localparam int INST_W = 32;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW_SW   = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_JALR    = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub / srai

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    localparam logic [INST_W-1:0] INST_NOP    = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [INST_W-1:0] INST_EBREAK = 32'h0010_0073;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;  // imm[31:12]
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one instruction word, six ways to look at it
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv32i_inst_t;

endpackage

/* common/rvc_pkg.sv */
package rvc_pkg;

    localparam int CINST_W = 16;

    localparam logic [1:0] QUAD_0    = 2'b00;
    localparam logic [1:0] QUAD_1    = 2'b01;
    localparam logic [1:0] QUAD_2    = 2'b10;
    localparam logic [1:0] QUAD_FULL = 2'b11;  // 32-bit word, not compressed

    // quadrant 0
    localparam logic [2:0] CF3_ADDI4SPN = 3'b000;
    localparam logic [2:0] CF3_LW       = 3'b010;
    localparam logic [2:0] CF3_SW       = 3'b110;

    // quadrant 1
    localparam logic [2:0] CF3_ADDI  = 3'b000;
    localparam logic [2:0] CF3_JAL   = 3'b001;
    localparam logic [2:0] CF3_LI    = 3'b010;
    localparam logic [2:0] CF3_LUI   = 3'b011;  // also c.addi16sp
    localparam logic [2:0] CF3_ARITH = 3'b100;
    localparam logic [2:0] CF3_J     = 3'b101;
    localparam logic [2:0] CF3_BEQZ  = 3'b110;
    localparam logic [2:0] CF3_BNEZ  = 3'b111;

    // quadrant 2
    localparam logic [2:0] CF3_SLLI      = 3'b000;
    localparam logic [2:0] CF3_LWSP      = 3'b010;
    localparam logic [2:0] CF3_JR_MV_ADD = 3'b100;
    localparam logic [2:0] CF3_SWSP      = 3'b110;

    // arith group, bits 11:10
    localparam logic [1:0] CA_OP_SRLI = 2'b00;
    localparam logic [1:0] CA_OP_SRAI = 2'b01;
    localparam logic [1:0] CA_OP_ANDI = 2'b10;
    localparam logic [1:0] CA_OP_REG  = 2'b11;

    // register-register ops, bits 6:5
    localparam logic [1:0] CA_F2_SUB = 2'b00;
    localparam logic [1:0] CA_F2_XOR = 2'b01;
    localparam logic [1:0] CA_F2_OR  = 2'b10;
    localparam logic [1:0] CA_F2_AND = 2'b11;

    localparam logic [1:0] PRIME_BASE = 2'b01;  // x8..x15

    typedef struct packed {
        logic [3:0] funct4;
        logic [4:0] rd_rs1;
        logic [4:0] rs2;
        logic [1:0] op;
    } cr_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic       imm_hi;  // bit 12
        logic [4:0] rd_rs1;
        logic [4:0] imm_lo;  // bits 6:2
        logic [1:0] op;
    } ci_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [5:0] imm;
        logic [4:0] rs2;
        logic [1:0] op;
    } css_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [7:0] imm;
        logic [2:0] rd_p;
        logic [1:0] op;
    } ciw_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] imm_hi;
        logic [2:0] rs1_p;
        logic [1:0] imm_lo;
        logic [2:0] rd_p;
        logic [1:0] op;
    } cl_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] imm_hi;
        logic [2:0] rs1_p;
        logic [1:0] imm_lo;
        logic [2:0] rs2_p;
        logic [1:0] op;
    } cs_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic [2:0] rd_rs1_p;
        logic [1:0] funct2;
        logic [2:0] rs2_p;
        logic [1:0] op;
    } ca_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] off_hi;  // bits 12:10
        logic [2:0] rs1_p;
        logic [4:0] off_lo;  // bits 6:2
        logic [1:0] op;
    } cb_t;

    typedef struct packed {
        logic [2:0]  funct3;
        logic [10:0] target;
        logic [1:0]  op;
    } cj_t;

    typedef union packed {
        cr_t  cr;
        ci_t  ci;
        css_t css;
        ciw_t ciw;
        cl_t  cl;
        cs_t  cs;
        ca_t  ca;
        cb_t  cb;
        cj_t  cj;
    } rvc_inst_t;

endpackage

/* sim.f */
common/rv32i_pkg.sv
common/rvc_pkg.sv
src/rvc_q0_expand.sv
src/rvc_q1_expand.sv
src/rvc_q2_expand.sv
src/rvc_expander.sv
sim/tb_rvc_expander.sv

/* sim/tb_rvc_expander.sv */
`timescale 1ns/1ns

module tb_rvc_expander;
    import rv32i_pkg::*;
    import rvc_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 10;
    localparam int N_RAND      = 500;  // random words per test
    localparam int N_CYCLES    = RST_CYCLES + 5 * N_RAND + 16 + 6 * 4;
    localparam int WATCHDOG_NS = CLK_PERIOD * N_CYCLES + 200;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        valid_i;
    rv32i_inst_t inst_i;
    logic        valid_o;
    rv32i_inst_t inst_o;

    logic [31:0] lfsr = 32'h66d5_003c;
    rv32i_inst_t last_exp = INST_NOP;  // what inst_o should hold
    rv32i_inst_t exp_q[$];
    logic        vld_q[$];
    int          err_cnt = 0;
    int          n_checks = 0;
    int          n_tests = 0;
    int          chk0 = 0;
    int          err0 = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rvc_expander DUT (
        .clk_i   (clk),
        .arst_n_i(arst_n),
        .valid_i (valid_i),
        .inst_i  (inst_i),
        .valid_o (valid_o),
        .inst_o  (inst_o)
    );

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] pack_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] pack_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] pack_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // expansion straight from the compressed spec tables
    function automatic rv32i_inst_t expand_ref(input logic [31:0] w);
        logic [15:0] c;
        logic [4:0]  rd;
        logic [4:0]  p97;  // prime reg at bits 9:7
        logic [4:0]  p42;  // prime reg at bits 4:2
        logic [31:0] ci;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic [31:0] r;
        c   = w[15:0];
        rd  = c[11:7];
        p97 = {2'b01, c[9:7]};
        p42 = {2'b01, c[4:2]};
        ci  = {{26{c[12]}}, c[12], c[6:2]};
        imm = '0;
        f3  = '0;
        r   = 32'h0000_0013;  // unlisted encodings
        if (c[1:0] == 2'b11) begin
            r = w;
        end
        case ({c[1:0], c[15:13]})
            5'b00_000: begin  // c.addi4spn
                imm = {22'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
                r = pack_i(imm[11:0], 5'd2, 3'b000, p42, 7'b0010011);
            end
            5'b00_010: begin
                imm = {25'b0, c[5], c[12:10], c[6], 2'b00};
                r = pack_i(imm[11:0], p97, 3'b010, p42, 7'b0000011);
            end
            5'b00_110: begin
                imm = {25'b0, c[5], c[12:10], c[6], 2'b00};
                r = pack_sw(imm[11:0], p42, p97);
            end
            5'b01_000: r = pack_i(ci[11:0], rd, 3'b000, rd, 7'b0010011);
            5'b01_010: r = pack_i(ci[11:0], 5'd0, 3'b000, rd, 7'b0010011);
            5'b01_001, 5'b01_101: begin
                imm = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
                       c[5:3], 1'b0};
                r = {imm[20], imm[10:1], imm[11], imm[19:12], 4'b0000,
                     ~c[15], 7'b1101111};  // c.jal links to x1
            end
            5'b01_011: begin
                if (rd == 5'd2) begin  // c.addi16sp
                    imm = {{22{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
                    r = pack_i(imm[11:0], 5'd2, 3'b000, 5'd2, 7'b0010011);
                end else begin
                    r = {{15{c[12]}}, c[6:2], rd, 7'b0110111};
                end
            end
            5'b01_100: begin
                if (c[11:10] == 2'b10) begin
                    r = pack_i(ci[11:0], p97, 3'b111, p97, 7'b0010011);
                end else if (!c[12] && c[11:10] != 2'b11) begin
                    r = pack_r({1'b0, c[10], 5'b0}, c[6:2], p97, 3'b101, p97, 7'b0010011);
                end else if (!c[12]) begin
                    case (c[6:5])
                        2'b00:   f3 = 3'b000;
                        2'b01:   f3 = 3'b100;
                        2'b10:   f3 = 3'b110;
                        default: f3 = 3'b111;
                    endcase
                    r = pack_r({1'b0, c[6:5] == 2'b00, 5'b0}, p42, p97, f3, p97, 7'b0110011);
                end
            end
            5'b01_110, 5'b01_111: begin
                imm = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
                r = {imm[12], imm[10:5], 5'd0, p97, 2'b00, c[13], imm[4:1], imm[11],
                     7'b1100011};
            end
            5'b10_000: if (!c[12]) r = pack_r(7'b0, c[6:2], rd, 3'b001, rd, 7'b0010011);
            5'b10_010: begin
                imm = {24'b0, c[3:2], c[12], c[6:4], 2'b00};
                r = pack_i(imm[11:0], 5'd2, 3'b010, rd, 7'b0000011);
            end
            5'b10_100: begin
                if (c[6:2] != 5'd0) begin
                    r = pack_r(7'b0, c[6:2], c[12] ? rd : 5'd0, 3'b000, rd, 7'b0110011);
                end else if (c[12] && rd == 5'd0) begin
                    r = 32'h0010_0073;  // ebreak
                end else begin
                    r = pack_i(12'b0, rd, 3'b000, {4'b0, c[12]}, 7'b1100111);
                end
            end
            5'b10_110: begin
                imm = {24'b0, c[8:7], c[12:9], 2'b00};
                r = pack_sw(imm[11:0], c[6:2], 5'd2);
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_inst(input rv32i_inst_t exp, input rv32i_inst_t got);
        n_checks++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: inst_o %08h, expected %08h", $time, got, exp);
        end
    endtask

    task automatic check_valid(input logic exp, input logic got);
        n_checks++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: valid_o %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic drive(input logic vld, input logic [31:0] word);
        @(negedge clk);
        valid_i = vld;
        inst_i  = word;
        if (vld) begin
            last_exp = expand_ref(word);
        end
        vld_q.push_back(vld);
        exp_q.push_back(last_exp);
    endtask

    // one idle cycle and then wait for the comparer to drain
    task automatic end_test(input string name);
        drive(1'b0, 32'h0);
        while (vld_q.size() != 0) @(negedge clk);
        $display("test %s: %0d checks, %0d errors", name, n_checks - chk0, err_cnt - err0);
        n_tests++;
        chk0 = n_checks;
        err0 = err_cnt;
    endtask

    // result of a drive is due at the negedge after the capturing posedge
    initial begin : compare_outputs
        rv32i_inst_t e_inst;
        logic        e_vld;
        bit          due;
        forever begin
            @(posedge clk);
            due = (vld_q.size() != 0);
            @(negedge clk);
            if (due) begin
                e_vld  = vld_q.pop_front();
                e_inst = exp_q.pop_front();
                check_valid(e_vld, valid_o);
                check_inst(e_inst, inst_o);
            end
        end
    end

    initial begin : stimulus
        logic [31:0] w;
        logic [31:0] v;
        arst_n  = 1'b0;
        valid_i = 1'b0;
        inst_i  = '0;
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_valid(1'b0, valid_o);
            check_inst(INST_NOP, inst_o);
            valid_i = 1'b1;  // must not leak through reset
        end
        arst_n  = 1'b1;
        valid_i = 1'b0;
        end_test("reset");

        for (int k = 0; k < N_RAND; k++) begin
            w = rand_bits(30);
            drive(1'b1, {w[29:0], QUAD_0});
        end
        end_test("quadrant 0");

        for (int k = 0; k < N_RAND; k++) begin
            w = rand_bits(30);
            drive(1'b1, {w[29:0], QUAD_1});
        end
        for (int k = 0; k < 8; k++) begin  // rd = sp selects addi16sp
            w = rand_bits(22);
            drive(1'b1, {w[21:6], 3'b011, w[5], 5'd2, w[4:0], QUAD_1});
        end
        end_test("quadrant 1");

        for (int k = 0; k < N_RAND; k++) begin
            w = rand_bits(30);
            drive(1'b1, {w[29:0], QUAD_2});
        end
        for (int k = 0; k < 8; k++) begin  // every mix of rd, rs2 and bit 12
            w = k;
            drive(1'b1, {16'h0, 3'b100, w[0], w[1] ? 5'd9 : 5'd0, w[2] ? 5'd17 : 5'd0,
                         QUAD_2});
        end
        end_test("quadrant 2");

        for (int k = 0; k < N_RAND; k++) begin
            w = rand_bits(30);
            drive(1'b1, {w[29:0], QUAD_FULL});
        end
        end_test("full width");

        for (int k = 0; k < N_RAND; k++) begin
            v = rand_bits(1);
            w = rand_bits(32);
            drive(v[0], w);
        end
        end_test("valid timing");

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* src/rvc_expander.sv */
`timescale 1ns/1ns

module rvc_expander (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   valid_i,
    input  rv32i_pkg::rv32i_inst_t inst_i,
    output logic                   valid_o,
    output rv32i_pkg::rv32i_inst_t inst_o
);
    import rv32i_pkg::*;
    import rvc_pkg::*;

    rvc_inst_t   cinst;
    rv32i_inst_t q0_inst;
    rv32i_inst_t q1_inst;
    rv32i_inst_t q2_inst;
    rv32i_inst_t exp_inst;

    assign cinst = inst_i[CINST_W-1:0];

    rvc_q0_expand u_q0 (.cinst_i(cinst), .inst_o(q0_inst));
    rvc_q1_expand u_q1 (.cinst_i(cinst), .inst_o(q1_inst));
    rvc_q2_expand u_q2 (.cinst_i(cinst), .inst_o(q2_inst));

    // quadrant is only looked at here
    always_comb begin
        unique case (cinst.cr.op)
            QUAD_0:    exp_inst = q0_inst;
            QUAD_1:    exp_inst = q1_inst;
            QUAD_2:    exp_inst = q2_inst;
            QUAD_FULL: exp_inst = inst_i;  // already 32-bit
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            inst_o  <= INST_NOP;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                inst_o <= exp_inst;  // hold otherwise
            end
        end
    end

    // every expansion and every pass-through word is a 32-bit encoding
    a_full_opcode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o |-> (inst_o.r.opcode[1:0] == 2'b11));

    a_rst_valid: assert property (@(posedge clk_i) !arst_n_i |-> !valid_o);

    a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !valid_i |=> $stable(inst_o));

endmodule

/* src/rvc_q0_expand.sv */
`timescale 1ns/1ns

module rvc_q0_expand (
    input  rvc_pkg::rvc_inst_t     cinst_i,
    output rv32i_pkg::rv32i_inst_t inst_o
);
    import rv32i_pkg::*;
    import rvc_pkg::*;

    always_comb begin
        inst_o = INST_NOP;
        case (cinst_i.ciw.funct3)
            CF3_ADDI4SPN: begin
                // nzuimm[5:4|9:6|2|3] sits in bits 12:5
                inst_o.i.imm    = {2'b00, cinst_i.ciw.imm[5:2], cinst_i.ciw.imm[7:6],
                                   cinst_i.ciw.imm[0], cinst_i.ciw.imm[1], 2'b00};
                inst_o.i.rs1    = REG_SP;
                inst_o.i.funct3 = F3_ADD_SUB;
                inst_o.i.rd     = {PRIME_BASE, cinst_i.ciw.rd_p};
                inst_o.i.opcode = OPC_OP_IMM;
            end
            CF3_LW: begin
                inst_o.i.imm    = {5'b0, cinst_i.cl.imm_lo[0], cinst_i.cl.imm_hi,
                                   cinst_i.cl.imm_lo[1], 2'b00};  // word scaled
                inst_o.i.rs1    = {PRIME_BASE, cinst_i.cl.rs1_p};
                inst_o.i.funct3 = F3_LW_SW;
                inst_o.i.rd     = {PRIME_BASE, cinst_i.cl.rd_p};
                inst_o.i.opcode = OPC_LOAD;
            end
            CF3_SW: begin
                // same offset layout as c.lw, split over the s-type fields
                inst_o.s.imm_11_5 = {5'b0, cinst_i.cs.imm_lo[0], cinst_i.cs.imm_hi[2]};
                inst_o.s.rs2      = {PRIME_BASE, cinst_i.cs.rs2_p};
                inst_o.s.rs1      = {PRIME_BASE, cinst_i.cs.rs1_p};
                inst_o.s.funct3   = F3_LW_SW;
                inst_o.s.imm_4_0  = {cinst_i.cs.imm_hi[1:0], cinst_i.cs.imm_lo[1], 2'b00};
                inst_o.s.opcode   = OPC_STORE;
            end
            default: inst_o = INST_NOP;  // reserved / fp loads and stores
        endcase
    end

endmodule

/* src/rvc_q1_expand.sv */
`timescale 1ns/1ns

module rvc_q1_expand (
    input  rvc_pkg::rvc_inst_t     cinst_i,
    output rv32i_pkg::rv32i_inst_t inst_o
);
    import rv32i_pkg::*;
    import rvc_pkg::*;

    logic [11:0] ci_imm;    // sign-extended 6-bit immediate
    logic [4:0]  rd_p;      // rd'/rs1' from bits 9:7
    logic [4:0]  rs2_p;
    logic [1:0]  arith_op;  // bits 11:10
    logic [2:0]  b_hi;
    logic [4:0]  b_lo;
    logic [10:0] jt;

    assign ci_imm   = {{6{cinst_i.ci.imm_hi}}, cinst_i.ci.imm_hi, cinst_i.ci.imm_lo};
    assign rd_p     = {PRIME_BASE, cinst_i.cb.rs1_p};
    assign rs2_p    = {PRIME_BASE, cinst_i.ca.rs2_p};
    assign arith_op = cinst_i.cb.off_hi[1:0];
    assign b_hi     = cinst_i.cb.off_hi;
    assign b_lo     = cinst_i.cb.off_lo;
    assign jt       = cinst_i.cj.target;

    always_comb begin
        inst_o = INST_NOP;
        case (cinst_i.ci.funct3)
            CF3_ADDI, CF3_LI: begin
                inst_o.i.imm    = ci_imm;
                inst_o.i.rs1    = (cinst_i.ci.funct3 == CF3_LI) ? REG_ZERO : cinst_i.ci.rd_rs1;
                inst_o.i.funct3 = F3_ADD_SUB;
                inst_o.i.rd     = cinst_i.ci.rd_rs1;
                inst_o.i.opcode = OPC_OP_IMM;
            end
            CF3_LUI: begin
                if (cinst_i.ci.rd_rs1 == REG_SP) begin
                    // c.addi16sp, nzimm[9|4|6|8:7|5]
                    inst_o.i.imm    = {{3{cinst_i.ci.imm_hi}}, cinst_i.ci.imm_lo[2:1],
                                       cinst_i.ci.imm_lo[3], cinst_i.ci.imm_lo[0],
                                       cinst_i.ci.imm_lo[4], 4'b0000};
                    inst_o.i.rs1    = REG_SP;
                    inst_o.i.funct3 = F3_ADD_SUB;
                    inst_o.i.rd     = REG_SP;
                    inst_o.i.opcode = OPC_OP_IMM;
                end else begin
                    inst_o.u.imm    = {{14{cinst_i.ci.imm_hi}}, cinst_i.ci.imm_hi,
                                       cinst_i.ci.imm_lo};
                    inst_o.u.rd     = cinst_i.ci.rd_rs1;
                    inst_o.u.opcode = OPC_LUI;
                end
            end
            CF3_ARITH: begin
                case (arith_op)
                    CA_OP_SRLI, CA_OP_SRAI: begin
                        if (!cinst_i.ci.imm_hi) begin  // shamt[5] must be 0 on rv32
                            inst_o.r.funct7 = (arith_op == CA_OP_SRAI) ? F7_ALT : F7_BASE;
                            inst_o.r.rs2    = cinst_i.ci.imm_lo;
                            inst_o.r.rs1    = rd_p;
                            inst_o.r.funct3 = F3_SRL_SRA;
                            inst_o.r.rd     = rd_p;
                            inst_o.r.opcode = OPC_OP_IMM;
                        end
                    end
                    CA_OP_ANDI: begin
                        inst_o.i.imm    = ci_imm;
                        inst_o.i.rs1    = rd_p;
                        inst_o.i.funct3 = F3_AND;
                        inst_o.i.rd     = rd_p;
                        inst_o.i.opcode = OPC_OP_IMM;
                    end
                    CA_OP_REG: begin
                        // bit 12 set is the rv64 word group
                        if (!cinst_i.ca.funct6[2]) begin
                            inst_o.r.funct7 = (cinst_i.ca.funct2 == CA_F2_SUB) ? F7_ALT : F7_BASE;
                            inst_o.r.rs2    = rs2_p;
                            inst_o.r.rs1    = rd_p;
                            inst_o.r.rd     = rd_p;
                            inst_o.r.opcode = OPC_OP;
                            case (cinst_i.ca.funct2)
                                CA_F2_SUB: inst_o.r.funct3 = F3_ADD_SUB;
                                CA_F2_XOR: inst_o.r.funct3 = F3_XOR;
                                CA_F2_OR:  inst_o.r.funct3 = F3_OR;
                                CA_F2_AND: inst_o.r.funct3 = F3_AND;
                            endcase
                        end
                    end
                endcase
            end
            CF3_JAL, CF3_J: begin
                // offset[11|4|9:8|10|6|7|3:1|5] in the cj target
                inst_o.j.imm_20    = jt[10];
                inst_o.j.imm_10_1  = {jt[6], jt[8:7], jt[4], jt[5], jt[0], jt[9], jt[3:1]};
                inst_o.j.imm_11    = jt[10];
                inst_o.j.imm_19_12 = {8{jt[10]}};
                inst_o.j.rd        = (cinst_i.cj.funct3 == CF3_JAL) ? REG_RA : REG_ZERO;
                inst_o.j.opcode    = OPC_JAL;
            end
            CF3_BEQZ, CF3_BNEZ: begin
                // offset[8|4:3] at 12:10, offset[7:6|2:1|5] at 6:2
                inst_o.b.imm_12   = b_hi[2];
                inst_o.b.imm_10_5 = {{3{b_hi[2]}}, b_lo[4:3], b_lo[0]};
                inst_o.b.rs2      = REG_ZERO;
                inst_o.b.rs1      = rd_p;
                inst_o.b.funct3   = (cinst_i.cb.funct3 == CF3_BEQZ) ? F3_BEQ : F3_BNE;
                inst_o.b.imm_4_1  = {b_hi[1:0], b_lo[2:1]};
                inst_o.b.imm_11   = b_hi[2];
                inst_o.b.opcode   = OPC_BRANCH;
            end
        endcase
    end

endmodule

/* src/rvc_q2_expand.sv */
`timescale 1ns/1ns

module rvc_q2_expand (
    input  rvc_pkg::rvc_inst_t     cinst_i,
    output rv32i_pkg::rv32i_inst_t inst_o
);
    import rv32i_pkg::*;
    import rvc_pkg::*;

    logic b12;  // splits jr/mv from jalr/add/ebreak

    assign b12 = cinst_i.cr.funct4[0];

    always_comb begin
        inst_o = INST_NOP;
        case (cinst_i.ci.funct3)
            CF3_SLLI: begin
                if (!cinst_i.ci.imm_hi) begin  // shamt[5] reserved on rv32
                    inst_o.r.funct7 = F7_BASE;
                    inst_o.r.rs2    = cinst_i.ci.imm_lo;
                    inst_o.r.rs1    = cinst_i.ci.rd_rs1;
                    inst_o.r.funct3 = F3_SLL;
                    inst_o.r.rd     = cinst_i.ci.rd_rs1;
                    inst_o.r.opcode = OPC_OP_IMM;
                end
            end
            CF3_LWSP: begin
                // uimm[5] at 12, uimm[4:2|7:6] at 6:2
                inst_o.i.imm    = {4'b0, cinst_i.ci.imm_lo[1:0], cinst_i.ci.imm_hi,
                                   cinst_i.ci.imm_lo[4:2], 2'b00};
                inst_o.i.rs1    = REG_SP;
                inst_o.i.funct3 = F3_LW_SW;
                inst_o.i.rd     = cinst_i.ci.rd_rs1;
                inst_o.i.opcode = OPC_LOAD;
            end
            CF3_JR_MV_ADD: begin
                if (cinst_i.cr.rs2 != REG_ZERO) begin
                    // c.mv adds to x0, c.add to rd itself
                    inst_o.r.funct7 = F7_BASE;
                    inst_o.r.rs2    = cinst_i.cr.rs2;
                    inst_o.r.rs1    = b12 ? cinst_i.cr.rd_rs1 : REG_ZERO;
                    inst_o.r.funct3 = F3_ADD_SUB;
                    inst_o.r.rd     = cinst_i.cr.rd_rs1;
                    inst_o.r.opcode = OPC_OP;
                end else if (b12 && (cinst_i.cr.rd_rs1 == REG_ZERO)) begin
                    inst_o = INST_EBREAK;
                end else begin
                    inst_o.i.imm    = '0;
                    inst_o.i.rs1    = cinst_i.cr.rd_rs1;
                    inst_o.i.funct3 = F3_JALR;
                    inst_o.i.rd     = b12 ? REG_RA : REG_ZERO;  // c.jalr links
                    inst_o.i.opcode = OPC_JALR;
                end
            end
            CF3_SWSP: begin
                inst_o.s.imm_11_5 = {4'b0, cinst_i.css.imm[1:0], cinst_i.css.imm[5]};
                inst_o.s.rs2      = cinst_i.css.rs2;
                inst_o.s.rs1      = REG_SP;
                inst_o.s.funct3   = F3_LW_SW;
                inst_o.s.imm_4_0  = {cinst_i.css.imm[4:2], 2'b00};
                inst_o.s.opcode   = OPC_STORE;
            end
            default: inst_o = INST_NOP;
        endcase
    end

endmodule
